// ==== logic/decode_pkg.sv ====
package decode_pkg;

	// datapath and field widths
	localparam int unsigned XLEN      = 32;
	localparam int unsigned REG_AW    = 5;
	localparam int unsigned ECODE_W   = 6;
	localparam int unsigned CSR_NUM_W = 14;

	// operation handed to the EX stage ALU
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor, alu_or,
		alu_xor, alu_sll, alu_srl, alu_sra, alu_lui, alu_eq
	} alu_op_e;

	// refresh tracking after writes to translation CSRs
	typedef enum logic {
		rf_idle,
		rf_pending
	} refresh_state_e;

	// major opcode in inst[31:26]
	typedef enum logic [5:0] {
		OPC_SPECIAL   = 6'b000000,
		OPC_CSR       = 6'b000001,
		OPC_LU12I     = 6'b000101,
		OPC_PCADDU12I = 6'b000111,
		OPC_LDST      = 6'b001010,
		OPC_JIRL      = 6'b010011,
		OPC_B         = 6'b010100,
		OPC_BL        = 6'b010101,
		OPC_BEQ       = 6'b010110,
		OPC_BNE       = 6'b010111,
		OPC_BLT       = 6'b011000,
		OPC_BGE       = 6'b011001,
		OPC_BLTU      = 6'b011010,
		OPC_BGEU      = 6'b011011
	} major_op_e;

	// minor opcode in inst[21:15] under the special major
	typedef enum logic [6:0] {
		OP3_SLLI_W   = 7'b0000001,
		OP3_SRLI_W   = 7'b0001001,
		OP3_SRAI_W   = 7'b0010001,
		OP3_ADD_W    = 7'b0100000,
		OP3_SUB_W    = 7'b0100010,
		OP3_SLT      = 7'b0100100,
		OP3_SLTU     = 7'b0100101,
		OP3_NOR      = 7'b0101000,
		OP3_AND      = 7'b0101001,
		OP3_OR       = 7'b0101010,
		OP3_XOR      = 7'b0101011,
		OP3_SLL_W    = 7'b0101110,
		OP3_SRL_W    = 7'b0101111,
		OP3_SRA_W    = 7'b0110000,
		OP3_BREAK    = 7'b1010100,
		OP3_SYSCALL  = 7'b1010110
	} op3r_e;

	// ertn is fully fixed below the major opcode
	localparam logic [25:0] ERTN_LOW = {4'b1001, 7'b0010000, 5'b01110, 10'b0};

	// exception codes
	localparam logic [ECODE_W-1:0] ECODE_NONE = 6'h00;
	localparam logic [ECODE_W-1:0] ECODE_SYS  = 6'h0b;
	localparam logic [ECODE_W-1:0] ECODE_BRK  = 6'h0c;
	localparam logic [ECODE_W-1:0] ECODE_INE  = 6'h0d;

	// CSRs whose write forces a pipeline refresh
	localparam logic [CSR_NUM_W-1:0] CSR_CRMD = 14'h000;
	localparam logic [CSR_NUM_W-1:0] CSR_ASID = 14'h018;
	localparam logic [CSR_NUM_W-1:0] CSR_DMW0 = 14'h180;
	localparam logic [CSR_NUM_W-1:0] CSR_DMW1 = 14'h181;

	// link register of bl
	localparam logic [REG_AW-1:0] REG_RA = 5'd1;

endpackage

// ==== logic/fetch_latch.sv ====
`timescale 1ns/100ps

module fetch_latch
	import decode_pkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  logic               pipe_tonext_valid_if,
	input  logic [XLEN-1:0]    inst_if,
	input  logic [XLEN-1:0]    pc_if,
	input  logic [ECODE_W-1:0] ecode_if,
	output logic [XLEN-1:0]    inst_id,
	output logic [XLEN-1:0]    pc_id,
	output logic [ECODE_W-1:0] ecode_id_in
);

	// IF to ID payload, moves only on the fetch handoff strobe
	always_ff @(posedge clk) begin
		if (pipe_tonext_valid_if) begin
			inst_id     <= inst_if;
			pc_id       <= pc_if;
			// fetch side exception rides along with the word
			ecode_id_in <= ecode_if;
		end
	end

endmodule

// ==== logic/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder
	import decode_pkg::*;
(
	input  logic [XLEN-1:0]      inst_id,
	input  logic [ECODE_W-1:0]   ecode_id_in,
	input  logic [XLEN-1:0]      rj_value,
	output alu_op_e              alu_op,
	output logic [XLEN-1:0]      imm,
	output logic [REG_AW-1:0]    rf_raddr1,
	output logic [REG_AW-1:0]    rf_raddr2,
	output logic [REG_AW-1:0]    dest,
	output logic                 rf_ren1,
	output logic                 rf_ren2,
	output logic                 src1_is_pc,
	output logic                 src2_is_imm,
	output logic                 src2_is_4,
	output logic                 br_src_sel,
	output logic                 br_taken_sure,
	output logic                 br_taken_yes,
	output logic                 br_taken_no,
	output logic                 ld_inst,
	output logic                 st_inst,
	output logic                 byte_we,
	output logic                 half_we,
	output logic                 word_we,
	output logic                 signed_ld,
	output logic                 res_from_mem,
	output logic                 mem_we,
	output logic                 gpr_we,
	output logic                 csr_inst,
	output logic                 csr_we,
	output logic                 csr_wmask_en,
	output logic [CSR_NUM_W-1:0] csr_num,
	output logic                 ertn_inst,
	output logic [ECODE_W-1:0]   ecode_id,
	output logic                 refresh_trigger
);

	major_op_e         major;
	op3r_e             op3r;
	logic [3:0]        op_25_22;
	logic [REG_AW-1:0] rd, rj, rk;
	logic              is_special, is_3r;
	logic              inst_add_w, inst_sub_w, inst_slt, inst_sltu;
	logic              inst_nor, inst_and, inst_or, inst_xor;
	logic              inst_sll_w, inst_srl_w, inst_sra_w;
	logic              inst_slli_w, inst_srli_w, inst_srai_w;
	logic              inst_slti, inst_sltui, inst_addi_w, inst_andi, inst_ori, inst_xori;
	logic              inst_lu12i_w, inst_pcaddu12i;
	logic              inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
	logic              inst_blt, inst_bge, inst_bltu, inst_bgeu;
	logic              inst_syscall, inst_break, inst_csrwr, inst_csrxchg;
	logic              alur_inst, sftr_inst, sfti_inst, alui_inst, lu_inst, br_cond;
	logic              illegal_inst;
	logic              need_si12, need_ui12, need_si16, need_si20, need_si26;

	// field split
	assign major    = major_op_e'(inst_id[31:26]);
	assign op3r     = op3r_e'(inst_id[21:15]);
	assign op_25_22 = inst_id[25:22];
	assign rd       = inst_id[4:0];
	assign rj       = inst_id[9:5];
	assign rk       = inst_id[14:10];

	assign is_special = (major == OPC_SPECIAL);
	assign is_3r      = is_special && (op_25_22 == 4'b0000);

	// three register forms
	assign inst_add_w   = is_3r && (op3r == OP3_ADD_W);
	assign inst_sub_w   = is_3r && (op3r == OP3_SUB_W);
	assign inst_slt     = is_3r && (op3r == OP3_SLT);
	assign inst_sltu    = is_3r && (op3r == OP3_SLTU);
	assign inst_nor     = is_3r && (op3r == OP3_NOR);
	assign inst_and     = is_3r && (op3r == OP3_AND);
	assign inst_or      = is_3r && (op3r == OP3_OR);
	assign inst_xor     = is_3r && (op3r == OP3_XOR);
	assign inst_sll_w   = is_3r && (op3r == OP3_SLL_W);
	assign inst_srl_w   = is_3r && (op3r == OP3_SRL_W);
	assign inst_sra_w   = is_3r && (op3r == OP3_SRA_W);
	assign inst_syscall = is_3r && (op3r == OP3_SYSCALL);
	assign inst_break   = is_3r && (op3r == OP3_BREAK);

	// shift by ui5, sits under op_25_22 = 0001
	assign inst_slli_w = is_special && (op_25_22 == 4'b0001) && (op3r == OP3_SLLI_W);
	assign inst_srli_w = is_special && (op_25_22 == 4'b0001) && (op3r == OP3_SRLI_W);
	assign inst_srai_w = is_special && (op_25_22 == 4'b0001) && (op3r == OP3_SRAI_W);

	// 12 bit immediate group, 011 and 100 are not kept
	assign inst_slti   = is_special && (op_25_22 == 4'b1000);
	assign inst_sltui  = is_special && (op_25_22 == 4'b1001);
	assign inst_addi_w = is_special && (op_25_22 == 4'b1010);
	assign inst_andi   = is_special && (op_25_22 == 4'b1101);
	assign inst_ori    = is_special && (op_25_22 == 4'b1110);
	assign inst_xori   = is_special && (op_25_22 == 4'b1111);

	assign inst_lu12i_w   = (major == OPC_LU12I) && !inst_id[25];
	assign inst_pcaddu12i = (major == OPC_PCADDU12I) && !inst_id[25];

	// jumps and branches
	assign inst_jirl = (major == OPC_JIRL);
	assign inst_b    = (major == OPC_B);
	assign inst_bl   = (major == OPC_BL);
	assign inst_beq  = (major == OPC_BEQ);
	assign inst_bne  = (major == OPC_BNE);
	assign inst_blt  = (major == OPC_BLT);
	assign inst_bge  = (major == OPC_BGE);
	assign inst_bltu = (major == OPC_BLTU);
	assign inst_bgeu = (major == OPC_BGEU);

	// loads: b h w bu hu; stores: b h w
	assign ld_inst = (major == OPC_LDST) && !op_25_22[2]
		&& (op_25_22[3] ? !op_25_22[1] : (op_25_22[1:0] != 2'b11));
	assign st_inst = (major == OPC_LDST) && (op_25_22[3:2] == 2'b01)
		&& (op_25_22[1:0] != 2'b11);

	// csr access, rj picks the flavour
	assign csr_inst     = (major == OPC_CSR) && (op_25_22[3:2] == 2'b00);
	assign inst_csrwr   = csr_inst && (rj == 5'd1);
	assign inst_csrxchg = csr_inst && (rj != 5'd0) && (rj != 5'd1);
	assign ertn_inst    = (major == OPC_CSR) && (inst_id[25:0] == ERTN_LOW);

	// class summaries
	assign alur_inst = inst_add_w || inst_sub_w || inst_slt || inst_sltu
		|| inst_nor || inst_and || inst_or || inst_xor;
	assign sftr_inst = inst_sll_w || inst_srl_w || inst_sra_w;
	assign sfti_inst = inst_slli_w || inst_srli_w || inst_srai_w;
	assign alui_inst = inst_slti || inst_sltui || inst_addi_w
		|| inst_andi || inst_ori || inst_xori;
	assign lu_inst   = inst_lu12i_w || inst_pcaddu12i;
	assign br_cond   = inst_beq || inst_bne || inst_blt || inst_bge || inst_bltu || inst_bgeu;

	// anything outside the kept set, bit 31 set included
	assign illegal_inst = !(alur_inst || sftr_inst || sfti_inst || alui_inst || lu_inst
		|| inst_jirl || inst_b || inst_bl || br_cond || ld_inst || st_inst
		|| csr_inst || ertn_inst || inst_syscall || inst_break);

	// alu operation, add is the fallback for address and link sums
	assign alu_op = (inst_sub_w) ? alu_sub :
		(inst_slt || inst_slti || inst_blt || inst_bge) ? alu_slt :
		(inst_sltu || inst_sltui || inst_bltu || inst_bgeu) ? alu_sltu :
		(inst_and || inst_andi) ? alu_and :
		(inst_nor) ? alu_nor :
		(inst_or || inst_ori) ? alu_or :
		(inst_xor || inst_xori) ? alu_xor :
		(inst_sll_w || inst_slli_w) ? alu_sll :
		(inst_srl_w || inst_srli_w) ? alu_srl :
		(inst_sra_w || inst_srai_w) ? alu_sra :
		(inst_lu12i_w) ? alu_lui :
		(inst_beq || inst_bne) ? alu_eq :
		alu_add;

	// immediate kinds, ui5 rides in the low bits of si12
	assign need_si12 = sfti_inst || inst_slti || inst_sltui || inst_addi_w || ld_inst || st_inst;
	assign need_ui12 = inst_andi || inst_ori || inst_xori;
	assign need_si16 = inst_jirl || br_cond;
	assign need_si20 = lu_inst;
	assign need_si26 = inst_b || inst_bl;

	assign imm = {XLEN{need_si12}} & {{20{inst_id[21]}}, inst_id[21:10]}
		| {XLEN{need_ui12}} & {20'b0, inst_id[21:10]}
		| {XLEN{need_si16}} & {{14{inst_id[25]}}, inst_id[25:10], 2'b0}
		| {XLEN{need_si20}} & {inst_id[24:5], 12'b0}
		| {XLEN{need_si26}} & {{4{inst_id[9]}}, inst_id[9:0], inst_id[25:10], 2'b0};

	// operand sources; conditional branches, stores and csr read rd as port 2
	assign rf_raddr1 = rj;
	assign rf_raddr2 = (br_cond || st_inst || csr_inst) ? rd : rk;
	assign rf_ren1   = inst_jirl || br_cond || ld_inst || st_inst || inst_csrxchg
		|| alui_inst || sfti_inst || sftr_inst || alur_inst;
	assign rf_ren2   = br_cond || st_inst || csr_inst || sftr_inst || alur_inst;

	assign src1_is_pc  = inst_jirl || inst_bl || inst_pcaddu12i;
	assign src2_is_imm = sfti_inst || alui_inst || ld_inst || st_inst || lu_inst;
	// link value is pc + 4
	assign src2_is_4   = inst_jirl || inst_bl;
	assign br_src_sel  = inst_jirl;

	// branch outcome classes for EX
	assign br_taken_sure = inst_jirl || inst_b || inst_bl;
	assign br_taken_yes  = inst_beq || inst_blt || inst_bltu;
	assign br_taken_no   = inst_bne || inst_bge || inst_bgeu;

	assign dest   = inst_bl ? REG_RA : rd;
	assign gpr_we = alur_inst || sftr_inst || sfti_inst || alui_inst || lu_inst
		|| inst_jirl || inst_bl || ld_inst || csr_inst;

	// memory access size and sign
	assign byte_we      = (ld_inst || st_inst) && (op_25_22[1:0] == 2'b00);
	assign half_we      = (ld_inst || st_inst) && (op_25_22[1:0] == 2'b01);
	assign word_we      = (ld_inst || st_inst) && (op_25_22[1:0] == 2'b10);
	assign signed_ld    = ld_inst && !op_25_22[3];
	assign res_from_mem = ld_inst;
	assign mem_we       = st_inst;

	// csrxchg with an all zero mask changes nothing
	assign csr_num      = inst_id[23:10];
	assign csr_wmask_en = inst_csrxchg;
	assign csr_we       = inst_csrwr || (inst_csrxchg && (rj_value != '0));

	// writes that alter translation need a refresh
	assign refresh_trigger = csr_we
		&& (csr_num inside {CSR_CRMD, CSR_ASID, CSR_DMW0, CSR_DMW1});

	// fetch exception first, then syscall, break, INE
	assign ecode_id = (ecode_id_in != ECODE_NONE) ? ecode_id_in :
		inst_syscall ? ECODE_SYS :
		inst_break ? ECODE_BRK :
		illegal_inst ? ECODE_INE :
		ECODE_NONE;

	// no clock here, so deferred checks on the settled decode
	always_comb begin
		assert #0 ($isunknown(inst_id) || !$isunknown(alu_op))
			else $error("alu_op unknown for a known instruction");
		assert #0 ($isunknown({inst_id, ecode_id_in}) || !illegal_inst
			|| (ecode_id_in != ECODE_NONE) || (ecode_id == ECODE_INE))
			else $error("illegal instruction without INE");
	end

endmodule

// ==== logic/operand_fetch.sv ====
`timescale 1ns/100ps

module operand_fetch
	import decode_pkg::*;
(
	input  logic              clk,
	input  logic [REG_AW-1:0] rf_raddr1,
	input  logic [REG_AW-1:0] rf_raddr2,
	input  logic              rf_we,
	input  logic [REG_AW-1:0] rf_waddr,
	input  logic [XLEN-1:0]   rf_wdata,
	input  logic              hzd_ex_r1,
	input  logic              hzd_mem_r1,
	input  logic              hzd_wb_r1,
	input  logic              hzd_ex_r2,
	input  logic              hzd_mem_r2,
	input  logic              hzd_wb_r2,
	input  logic [XLEN-1:0]   fwd_ex_data,
	input  logic [XLEN-1:0]   fwd_mem_data,
	input  logic [XLEN-1:0]   fwd_wb_data,
	output logic [XLEN-1:0]   rj_value,
	output logic [XLEN-1:0]   rkd_value
);

	// r0 has no storage
	logic [XLEN-1:0] regs [1:31];
	logic [XLEN-1:0] rf_rdata1;
	logic [XLEN-1:0] rf_rdata2;

	// youngest producer wins
	function automatic logic [XLEN-1:0] bypass(
		input logic            ex,
		input logic            mem,
		input logic            wb,
		input logic [XLEN-1:0] ex_data,
		input logic [XLEN-1:0] mem_data,
		input logic [XLEN-1:0] wb_data,
		input logic [XLEN-1:0] rf_data
	);
		if (ex)
			return ex_data;
		if (mem)
			return mem_data;
		if (wb)
			return wb_data;
		return rf_data;
	endfunction

	// write port from WB, r0 writes dropped
	always_ff @(posedge clk) begin
		if (rf_we && (rf_waddr != '0)) begin
			regs[rf_waddr] <= rf_wdata;
		end
	end

	// asynchronous reads of the stored value
	assign rf_rdata1 = (rf_raddr1 == '0) ? '0 : regs[rf_raddr1];
	assign rf_rdata2 = (rf_raddr2 == '0) ? '0 : regs[rf_raddr2];

	assign rj_value  = bypass(hzd_ex_r1, hzd_mem_r1, hzd_wb_r1,
		fwd_ex_data, fwd_mem_data, fwd_wb_data, rf_rdata1);
	assign rkd_value = bypass(hzd_ex_r2, hzd_mem_r2, hzd_wb_r2,
		fwd_ex_data, fwd_mem_data, fwd_wb_data, rf_rdata2);

	// WB must name a real register when it writes
	a_waddr_known: assert property (@(posedge clk) rf_we |-> !$isunknown(rf_waddr))
		else $error("register write with unknown address");

endmodule

// ==== logic/refresh_fsm.sv ====
`timescale 1ns/100ps

module refresh_fsm
	import decode_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic pipe_valid_id,
	input  logic pipe_tonext_valid_id,
	input  logic refresh_trigger,
	input  logic ex_ertn_flush,
	input  logic has_int,
	output logic has_int_id,
	output logic needs_refresh_id
);

	refresh_state_e state;

	// flush wins over a new trigger
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= rf_idle;
		end else if (ex_ertn_flush) begin
			state <= rf_idle;
		end else if (pipe_tonext_valid_id && refresh_trigger) begin
			// trigger leaves ID, everything after it gets marked
			state <= rf_pending;
		end
	end

	// marked instructions are wiped later in the pipe
	assign has_int_id = pipe_valid_id
		&& (has_int || ex_ertn_flush || (state == rf_pending));
	assign needs_refresh_id = pipe_valid_id && (state == rf_pending);

	// a refresh request always travels as an interrupt too
	a_refresh_is_int: assert property (
		@(posedge clk) disable iff (reset) needs_refresh_id |-> has_int_id
	) else $error("needs_refresh_id without has_int_id");

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage
	import decode_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	// stage control
	input  logic                 pipe_tonext_valid_if,
	input  logic                 pipe_tonext_valid_id,
	input  logic                 pipe_valid_id,
	input  logic                 has_int,
	input  logic                 ex_ertn_flush,
	// from fetch
	input  logic [XLEN-1:0]      inst_if,
	input  logic [XLEN-1:0]      pc_if,
	input  logic [ECODE_W-1:0]   ecode_if,
	// register write from WB
	input  logic                 rf_we,
	input  logic [REG_AW-1:0]    rf_waddr,
	input  logic [XLEN-1:0]      rf_wdata,
	// hazard levels and forwarded results
	input  logic                 hzd_ex_r1,
	input  logic                 hzd_mem_r1,
	input  logic                 hzd_wb_r1,
	input  logic                 hzd_ex_r2,
	input  logic                 hzd_mem_r2,
	input  logic                 hzd_wb_r2,
	input  logic [XLEN-1:0]      fwd_ex_data,
	input  logic [XLEN-1:0]      fwd_mem_data,
	input  logic [XLEN-1:0]      fwd_wb_data,
	// to EX
	output logic [XLEN-1:0]      pc_id,
	output alu_op_e              alu_op,
	output logic [XLEN-1:0]      imm,
	output logic [XLEN-1:0]      rj_value,
	output logic [XLEN-1:0]      rkd_value,
	output logic [REG_AW-1:0]    rf_raddr1,
	output logic [REG_AW-1:0]    rf_raddr2,
	output logic [REG_AW-1:0]    dest,
	output logic                 rf_ren1,
	output logic                 rf_ren2,
	output logic                 src1_is_pc,
	output logic                 src2_is_imm,
	output logic                 src2_is_4,
	output logic                 br_src_sel,
	output logic                 br_taken_sure,
	output logic                 br_taken_yes,
	output logic                 br_taken_no,
	output logic                 ld_inst,
	output logic                 st_inst,
	output logic                 byte_we,
	output logic                 half_we,
	output logic                 word_we,
	output logic                 signed_ld,
	output logic                 res_from_mem,
	output logic                 mem_we,
	output logic                 gpr_we,
	output logic                 csr_inst,
	output logic                 csr_we,
	output logic                 csr_wmask_en,
	output logic [CSR_NUM_W-1:0] csr_num,
	output logic                 ertn_inst,
	output logic [ECODE_W-1:0]   ecode_id,
	output logic                 has_int_id,
	output logic                 needs_refresh_id
);

	logic [XLEN-1:0]    inst_id;
	logic [ECODE_W-1:0] ecode_id_in;
	logic               refresh_trigger;

	fetch_latch fetch_latch_i (
		.clk, .reset, .pipe_tonext_valid_if,
		.inst_if, .pc_if, .ecode_if,
		.inst_id, .pc_id, .ecode_id_in
	);

	// decode is purely combinational off the latch
	inst_decoder inst_decoder_i (
		.inst_id, .ecode_id_in, .rj_value,
		.alu_op, .imm, .rf_raddr1, .rf_raddr2, .dest, .rf_ren1, .rf_ren2,
		.src1_is_pc, .src2_is_imm, .src2_is_4, .br_src_sel,
		.br_taken_sure, .br_taken_yes, .br_taken_no,
		.ld_inst, .st_inst, .byte_we, .half_we, .word_we, .signed_ld,
		.res_from_mem, .mem_we, .gpr_we,
		.csr_inst, .csr_we, .csr_wmask_en, .csr_num, .ertn_inst,
		.ecode_id, .refresh_trigger
	);

	operand_fetch operand_fetch_i (
		.clk, .rf_raddr1, .rf_raddr2, .rf_we, .rf_waddr, .rf_wdata,
		.hzd_ex_r1, .hzd_mem_r1, .hzd_wb_r1, .hzd_ex_r2, .hzd_mem_r2, .hzd_wb_r2,
		.fwd_ex_data, .fwd_mem_data, .fwd_wb_data,
		.rj_value, .rkd_value
	);

	// interrupt marking of the ID slot
	refresh_fsm refresh_fsm_i (
		.clk, .reset, .pipe_valid_id, .pipe_tonext_valid_id,
		.refresh_trigger, .ex_ertn_flush, .has_int,
		.has_int_id, .needs_refresh_id
	);

endmodule

// ==== bench/clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen (
	output logic clk,
	output logic reset
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// held over five rising edges, released just after the fifth
	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

// ==== bench/decode_stage_tb.sv ====
`timescale 1ns/100ps

module decode_stage_tb
	import decode_pkg::*;
();

	// loongarch32 opcode fields, upper bits of each format
	localparam logic [16:0] OP_ADD_W     = 17'h00020;
	localparam logic [16:0] OP_SUB_W     = 17'h00022;
	localparam logic [16:0] OP_MUL_W     = 17'h00038;
	localparam logic [16:0] OP_SLLI_W    = 17'h00081;
	localparam logic [16:0] OP_BREAK     = 17'h00054;
	localparam logic [16:0] OP_SYSCALL   = 17'h00056;
	localparam logic [9:0]  OP_ORI       = 10'h00e;
	localparam logic [9:0]  OP_LD_H      = 10'h0a1;
	localparam logic [9:0]  OP_LD_D      = 10'h0a3;
	localparam logic [9:0]  OP_ST_W      = 10'h0a6;
	localparam logic [9:0]  OP_LD_BU     = 10'h0a8;
	localparam logic [6:0]  OP_LU12I_W   = 7'h0a;
	localparam logic [6:0]  OP_PCADDU12I = 7'h0e;
	localparam logic [5:0]  OP_JIRL      = 6'h13;
	localparam logic [5:0]  OP_BL        = 6'h15;
	localparam logic [5:0]  OP_BEQ       = 6'h16;
	localparam logic [5:0]  OP_BNE       = 6'h17;
	localparam logic [7:0]  OP_CSR       = 8'h04;
	localparam logic [31:0] INST_ERTN    = 32'h0648_3800;

	logic clk, reset;
	logic pipe_tonext_valid_if, pipe_tonext_valid_id, pipe_valid_id, has_int, ex_ertn_flush;
	logic [31:0] inst_if, pc_if, pc_id, imm, rj_value, rkd_value, rf_wdata;
	logic [31:0] fwd_ex_data, fwd_mem_data, fwd_wb_data;
	logic [5:0] ecode_if, ecode_id;
	logic rf_we;
	logic [4:0] rf_waddr, rf_raddr1, rf_raddr2, dest;
	logic hzd_ex_r1, hzd_mem_r1, hzd_wb_r1, hzd_ex_r2, hzd_mem_r2, hzd_wb_r2;
	alu_op_e alu_op;
	logic rf_ren1, rf_ren2, src1_is_pc, src2_is_imm, src2_is_4, br_src_sel;
	logic br_taken_sure, br_taken_yes, br_taken_no, ld_inst, st_inst;
	logic byte_we, half_we, word_we, signed_ld, res_from_mem, mem_we, gpr_we;
	logic csr_inst, csr_we, csr_wmask_en, ertn_inst, has_int_id, needs_refresh_id;
	logic [13:0] csr_num;
	integer seed;

	clk_gen clk_gen_i (.clk, .reset);

	decode_stage decode_stage_i (.*);

	// instruction formats
	function automatic logic [31:0] three_reg(input logic [16:0] op, input logic [4:0] rk,
		input logic [4:0] rj, input logic [4:0] rd);
		return {op, rk, rj, rd};
	endfunction

	function automatic logic [31:0] imm12_form(input logic [9:0] op, input logic [11:0] si12,
		input logic [4:0] rj, input logic [4:0] rd);
		return {op, si12, rj, rd};
	endfunction

	function automatic logic [31:0] upper_imm(input logic [6:0] op, input logic [19:0] si20,
		input logic [4:0] rd);
		return {op, si20, rd};
	endfunction

	// offs26 is split, low half sits above the high part
	function automatic logic [31:0] jump26(input logic [5:0] op, input logic [25:0] offs);
		return {op, offs[15:0], offs[25:16]};
	endfunction

	function automatic logic [31:0] csr_access(input logic [13:0] num, input logic [4:0] rj,
		input logic [4:0] rd);
		return {OP_CSR, num, rj, rd};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "decode stage testbench stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] act,
		input logic [31:0] expv);
		assert (act === expv)
		else abort_run($sformatf("mismatch %s expected %h actual %h", name, expv, act));
	endtask

	task automatic next_cycle;
		@(posedge clk);
		#1;
	endtask

	// one cycle strobe into the latch, outputs checked mid cycle
	task automatic load_inst(input logic [31:0] inst, input logic [5:0] ecode);
		next_cycle();
		inst_if = inst;
		pc_if = pc_if + 32'd4;
		ecode_if = ecode;
		pipe_tonext_valid_if = 1'b1;
		next_cycle();
		pipe_tonext_valid_if = 1'b0;
		#2;
		check_value("pc_id", pc_id, pc_if);
	endtask

	task automatic check_arith(input alu_op_e op, input logic [4:0] rd, input logic imm_src);
		check_value("alu_op", alu_op, op);
		check_value("dest", dest, rd);
		check_value("gpr_we", gpr_we, 1'b1);
		check_value("src2_is_imm", src2_is_imm, imm_src);
		check_value("ecode_id", ecode_id, 6'h00);
	endtask

	task automatic wait_reset_release;
		int cycles;
		cycles = 0;
		while (reset !== 1'b0) begin
			@(posedge clk);
			cycles++;
			if (cycles > 20)
				abort_run("reset was never released");
		end
		#1;
	endtask

	task automatic reset_values;
		pipe_valid_id = 1'b1;
		#2;
		check_value("has_int_id", has_int_id, 1'b0);
		check_value("needs_refresh_id", needs_refresh_id, 1'b0);
	endtask

	task automatic alu_decode;
		load_inst(three_reg(OP_ADD_W, 5'd4, 5'd3, 5'd7), 6'h00);
		check_arith(alu_add, 5'd7, 1'b0);
		check_value("rf_ren1", rf_ren1, 1'b1);
		check_value("rf_ren2", rf_ren2, 1'b1);
		load_inst(three_reg(OP_SUB_W, 5'd9, 5'd8, 5'd10), 6'h00);
		check_arith(alu_sub, 5'd10, 1'b0);
		// ui12 is zero extended even with bit 11 set
		load_inst(imm12_form(OP_ORI, 12'habc, 5'd5, 5'd6), 6'h00);
		check_arith(alu_or, 5'd6, 1'b1);
		check_value("imm", imm, 32'h0000_0abc);
		check_value("rf_ren2", rf_ren2, 1'b0);
		load_inst(three_reg(OP_SLLI_W, 5'd13, 5'd2, 5'd11), 6'h00);
		check_arith(alu_sll, 5'd11, 1'b1);
		check_value("imm[4:0]", imm[4:0], 5'd13);
		load_inst(upper_imm(OP_LU12I_W, 20'h80001, 5'd12), 6'h00);
		check_arith(alu_lui, 5'd12, 1'b1);
		check_value("imm", imm, 32'h8000_1000);
		check_value("rf_ren1", rf_ren1, 1'b0);
		load_inst(upper_imm(OP_PCADDU12I, 20'h12345, 5'd13), 6'h00);
		check_arith(alu_add, 5'd13, 1'b1);
		check_value("imm", imm, 32'h1234_5000);
		check_value("src1_is_pc", src1_is_pc, 1'b1);
	endtask

	task automatic branch_mem_decode;
		logic [25:0] offs;
		// beq r3, r4 with offset -2 words
		load_inst({OP_BEQ, 16'hfffe, 5'd3, 5'd4}, 6'h00);
		check_value("alu_op", alu_op, alu_eq);
		check_value("br_taken_yes", br_taken_yes, 1'b1);
		check_value("br_taken_no", br_taken_no, 1'b0);
		check_value("br_src_sel", br_src_sel, 1'b0);
		check_value("imm", imm, 32'hffff_fff8);
		load_inst({OP_BNE, 16'h0010, 5'd3, 5'd4}, 6'h00);
		check_value("br_taken_no", br_taken_no, 1'b1);
		check_value("br_taken_yes", br_taken_yes, 1'b0);
		// jirl r0, r1, 16 bytes
		load_inst({OP_JIRL, 16'h0004, 5'd1, 5'd0}, 6'h00);
		check_value("br_src_sel", br_src_sel, 1'b1);
		check_value("br_taken_sure", br_taken_sure, 1'b1);
		check_value("imm", imm, 32'h0000_0010);
		offs = 26'h2abcdef;
		load_inst(jump26(OP_BL, offs), 6'h00);
		check_value("dest", dest, 5'd1);
		check_value("src1_is_pc", src1_is_pc, 1'b1);
		check_value("src2_is_4", src2_is_4, 1'b1);
		check_value("br_taken_sure", br_taken_sure, 1'b1);
		check_value("imm", imm, {{4{offs[25]}}, offs, 2'b00});
		// store data register is rd
		load_inst(imm12_form(OP_ST_W, 12'h804, 5'd3, 5'd17), 6'h00);
		check_value("rf_raddr2", rf_raddr2, 5'd17);
		check_value("st_inst", st_inst, 1'b1);
		check_value("ld_inst", ld_inst, 1'b0);
		check_value("mem_we", mem_we, 1'b1);
		check_value("word_we", word_we, 1'b1);
		check_value("gpr_we", gpr_we, 1'b0);
		check_value("imm", imm, 32'hffff_f804);
		load_inst(imm12_form(OP_LD_BU, 12'h010, 5'd3, 5'd18), 6'h00);
		check_value("ld_inst", ld_inst, 1'b1);
		check_value("byte_we", byte_we, 1'b1);
		check_value("signed_ld", signed_ld, 1'b0);
		check_value("res_from_mem", res_from_mem, 1'b1);
		load_inst(imm12_form(OP_LD_H, 12'h002, 5'd3, 5'd19), 6'h00);
		check_value("half_we", half_we, 1'b1);
		check_value("byte_we", byte_we, 1'b0);
		check_value("signed_ld", signed_ld, 1'b1);
	endtask

	task automatic exception_codes;
		load_inst({OP_SYSCALL, 15'h0011}, 6'h00);
		check_value("ecode_id", ecode_id, 6'h0b);
		load_inst({OP_BREAK, 15'h0002}, 6'h00);
		check_value("ecode_id", ecode_id, 6'h0c);
		load_inst(INST_ERTN, 6'h00);
		check_value("ertn_inst", ertn_inst, 1'b1);
		check_value("ecode_id", ecode_id, 6'h00);
		// removed and malformed encodings
		load_inst(three_reg(OP_MUL_W, 5'd2, 5'd3, 5'd4), 6'h00);
		check_value("ecode_id", ecode_id, 6'h0d);
		check_value("ertn_inst", ertn_inst, 1'b0);
		load_inst(32'h8410_0c41, 6'h00);
		check_value("ecode_id", ecode_id, 6'h0d);
		load_inst(imm12_form(OP_LD_D, 12'h008, 5'd3, 5'd4), 6'h00);
		check_value("ecode_id", ecode_id, 6'h0d);
		// fetch side code outranks decode
		load_inst(three_reg(OP_ADD_W, 5'd1, 5'd2, 5'd3), 6'h08);
		check_value("ecode_id", ecode_id, 6'h08);
		load_inst({OP_SYSCALL, 15'h0000}, 6'h01);
		check_value("ecode_id", ecode_id, 6'h01);
	endtask

	task automatic regfile_bypass;
		logic [31:0] model [0:31];
		int i;
		model[0] = '0;
		for (i = 1; i < 32; i++) begin
			next_cycle();
			rf_we = 1'b1;
			rf_waddr = 5'(i);
			rf_wdata = $random(seed);
			model[i] = rf_wdata;
		end
		// r0 must swallow this
		next_cycle();
		rf_waddr = 5'd0;
		rf_wdata = 32'hdead_beef;
		next_cycle();
		rf_we = 1'b0;
		for (i = 0; i < 32; i += 3) begin
			load_inst(three_reg(OP_ADD_W, 5'(31 - i), 5'(i), 5'd2), 6'h00);
			check_value("rj_value", rj_value, model[i]);
			check_value("rkd_value", rkd_value, model[31 - i]);
		end
		load_inst(three_reg(OP_ADD_W, 5'd4, 5'd3, 5'd2), 6'h00);
		next_cycle();
		fwd_ex_data = 32'h1111_0001;
		fwd_mem_data = 32'h2222_0002;
		fwd_wb_data = 32'h3333_0003;
		{hzd_ex_r1, hzd_mem_r1, hzd_wb_r1} = 3'b111;
		{hzd_ex_r2, hzd_mem_r2, hzd_wb_r2} = 3'b011;
		#2;
		check_value("rj_value", rj_value, 32'h1111_0001);
		check_value("rkd_value", rkd_value, 32'h2222_0002);
		next_cycle();
		hzd_ex_r1 = 1'b0;
		hzd_mem_r2 = 1'b0;
		#2;
		check_value("rj_value", rj_value, 32'h2222_0002);
		check_value("rkd_value", rkd_value, 32'h3333_0003);
		next_cycle();
		hzd_mem_r1 = 1'b0;
		hzd_wb_r2 = 1'b0;
		#2;
		check_value("rj_value", rj_value, 32'h3333_0003);
		check_value("rkd_value", rkd_value, model[4]);
		next_cycle();
		hzd_wb_r1 = 1'b0;
		#2;
		check_value("rj_value", rj_value, model[3]);
	endtask

	// ID instruction handed on for one edge
	task automatic pass_to_ex;
		next_cycle();
		pipe_tonext_valid_id = 1'b1;
		next_cycle();
		pipe_tonext_valid_id = 1'b0;
		#2;
	endtask

	task automatic flush_ertn;
		next_cycle();
		ex_ertn_flush = 1'b1;
		next_cycle();
		ex_ertn_flush = 1'b0;
		#2;
	endtask

	task automatic check_marks(input logic int_exp, input logic refresh_exp);
		check_value("has_int_id", has_int_id, int_exp);
		check_value("needs_refresh_id", needs_refresh_id, refresh_exp);
	endtask

	task automatic refresh_marking;
		// csrwr CRMD, then DMW1
		load_inst(csr_access(14'h000, 5'd1, 5'd4), 6'h00);
		check_value("csr_we", csr_we, 1'b1);
		check_value("csr_inst", csr_inst, 1'b1);
		check_value("csr_num", csr_num, 14'h000);
		check_value("csr_wmask_en", csr_wmask_en, 1'b0);
		pass_to_ex();
		check_marks(1'b1, 1'b1);
		flush_ertn();
		check_marks(1'b0, 1'b0);
		load_inst(csr_access(14'h181, 5'd1, 5'd4), 6'h00);
		check_value("csr_num", csr_num, 14'h181);
		pass_to_ex();
		check_marks(1'b1, 1'b1);
		flush_ertn();
		check_marks(1'b0, 1'b0);
		// PRMD write and a plain CRMD read stay quiet
		load_inst(csr_access(14'h001, 5'd1, 5'd4), 6'h00);
		pass_to_ex();
		check_marks(1'b0, 1'b0);
		load_inst(csr_access(14'h000, 5'd0, 5'd4), 6'h00);
		check_value("csr_we", csr_we, 1'b0);
		pass_to_ex();
		check_marks(1'b0, 1'b0);
		next_cycle();
		has_int = 1'b1;
		#2;
		check_marks(1'b1, 1'b0);
		next_cycle();
		has_int = 1'b0;
	endtask

	initial begin
		seed = 32'h9177_3f05;
		pipe_tonext_valid_if = 1'b0;
		pipe_tonext_valid_id = 1'b0;
		pipe_valid_id = 1'b0;
		has_int = 1'b0;
		ex_ertn_flush = 1'b0;
		inst_if = '0;
		pc_if = 32'h1c00_0000;
		ecode_if = '0;
		rf_we = 1'b0;
		rf_waddr = '0;
		rf_wdata = '0;
		{hzd_ex_r1, hzd_mem_r1, hzd_wb_r1} = 3'b000;
		{hzd_ex_r2, hzd_mem_r2, hzd_wb_r2} = 3'b000;
		fwd_ex_data = '0;
		fwd_mem_data = '0;
		fwd_wb_data = '0;
		wait_reset_release();
		reset_values();
		alu_decode();
		branch_mem_decode();
		exception_codes();
		regfile_bypass();
		refresh_marking();
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== compile.f ====
logic/decode_pkg.sv
logic/fetch_latch.sv
logic/inst_decoder.sv
logic/operand_fetch.sv
logic/refresh_fsm.sv
logic/decode_stage.sv
bench/clk_gen.sv
bench/decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - logic/decode_pkg.sv
  - logic/fetch_latch.sv
  - logic/inst_decoder.sv
  - logic/operand_fetch.sv
  - logic/refresh_fsm.sv
  - logic/decode_stage.sv
  - target: simulation
    files:
      - bench/clk_gen.sv
      - bench/decode_stage_tb.sv
